//--- hw/bs_config_pkg.sv
package bs_config_pkg;

    // Program counter width
    parameter int XLEN = 32;

    // ROB holds 64 entries
    parameter int ROB_IDX_W = 6;

    // Load and store queues, 16 entries each
    parameter int LSQ_IDX_W = 4;

    // Four in-flight conditional branches
    parameter int DEFAULT_NUM_CKPT = 4;

endpackage

//--- hw/bs_types_pkg.sv
package bs_types_pkg;

    // State saved at dispatch of a conditional branch
    typedef struct packed {
        logic [bs_config_pkg::XLEN-1:0]      pc;
        logic [bs_config_pkg::ROB_IDX_W-1:0] rob_tail;
        logic [bs_config_pkg::LSQ_IDX_W-1:0] lq_tail;
        logic [bs_config_pkg::LSQ_IDX_W-1:0] sq_tail;
    } checkpoint_t;

    // Result of comparing the real next PC with the prediction
    typedef enum logic [1:0] {
        RES_NONE,
        RES_CORRECT,
        RES_MISPREDICT
    } resolve_e;

endpackage

//--- hw/ckpt_write_if.sv
`timescale 1ns/10ps

interface ckpt_write_if #(
    parameter int NUM_CKPT = bs_config_pkg::DEFAULT_NUM_CKPT
);
    import bs_types_pkg::*;

    // One-hot slot, zero when nothing is written
    logic [NUM_CKPT-1:0] write;
    checkpoint_t         entry;
    logic [NUM_CKPT-1:0] mask;
    // Registered valid bits of all slots
    logic [NUM_CKPT-1:0] live;

    modport alloc (output write, output entry, output mask, input live);
    modport file (input write, input entry, input mask, output live);

endinterface

//--- hw/ckpt_read_if.sv
`timescale 1ns/10ps

interface ckpt_read_if #(
    parameter int NUM_CKPT = bs_config_pkg::DEFAULT_NUM_CKPT
);
    import bs_types_pkg::*;

    checkpoint_t [NUM_CKPT-1:0]         entries;
    logic [NUM_CKPT-1:0][NUM_CKPT-1:0] masks;
    logic [NUM_CKPT-1:0]               live;
    // Slots to invalidate at the next edge
    logic [NUM_CKPT-1:0]               free;
    // Branch bit to drop from every mask
    logic [NUM_CKPT-1:0]               clear;

    modport file (
        output entries, output masks, output live,
        input free, input clear
    );
    modport resolver (
        input entries, input masks, input live,
        output free, output clear
    );

endinterface

//--- hw/checkpoint_alloc.sv
`timescale 1ns/10ps

module checkpoint_alloc #(
    parameter int NUM_CKPT = bs_config_pkg::DEFAULT_NUM_CKPT
) (
    input  logic                                dispatch_valid,
    input  logic [bs_config_pkg::XLEN-1:0]      dispatch_pc,
    input  logic [bs_config_pkg::ROB_IDX_W-1:0] dispatch_rob_tail,
    input  logic [bs_config_pkg::LSQ_IDX_W-1:0] dispatch_lq_tail,
    input  logic [bs_config_pkg::LSQ_IDX_W-1:0] dispatch_sq_tail,
    input  bs_types_pkg::resolve_e              outcome,
    ckpt_write_if.alloc                         wr,
    output logic [NUM_CKPT-1:0]                 dispatch_tag,
    output logic                                stack_full
);
    import bs_types_pkg::*;

    logic [NUM_CKPT-1:0] free_slots;
    logic [NUM_CKPT-1:0] lowest_free;
    logic                write_en;

    assign free_slots = ~wr.live;

    // Isolate the lowest set bit
    assign lowest_free = free_slots & (~free_slots + NUM_CKPT'(1));

    assign stack_full = &wr.live;

    // Tag stays one-hot when full, slot 0 by convention
    assign dispatch_tag = stack_full ? NUM_CKPT'(1) : lowest_free;

    // Wrong-path dispatch during a mispredict is dropped
    assign write_en = dispatch_valid && !stack_full && (outcome != RES_MISPREDICT);

    assign wr.write = write_en ? dispatch_tag : '0;

    assign wr.entry = '{
        pc:       dispatch_pc,
        rob_tail: dispatch_rob_tail,
        lq_tail:  dispatch_lq_tail,
        sq_tail:  dispatch_sq_tail
    };

    // Own bit plus every older branch still in flight
    assign wr.mask = wr.live | dispatch_tag;

endmodule

//--- hw/checkpoint_file.sv
`timescale 1ns/10ps

module checkpoint_file #(
    parameter int NUM_CKPT = bs_config_pkg::DEFAULT_NUM_CKPT
) (
    input  logic         clock,
    input  logic         reset,
    ckpt_write_if.file   wr,
    ckpt_read_if.file    rd
);
    import bs_types_pkg::*;

    checkpoint_t [NUM_CKPT-1:0]         entries;
    logic [NUM_CKPT-1:0][NUM_CKPT-1:0] masks;
    logic [NUM_CKPT-1:0]               live;

    // Valid bits and masks
    always_ff @(posedge clock) begin
        if (reset) begin
            live  <= '0;
            masks <= '0;
        end else begin
            for (int i = 0; i < NUM_CKPT; i++) begin
                if (wr.write[i]) begin
                    // New slot wins over a free of the same slot
                    live[i]  <= 1'b1;
                    masks[i] <= wr.mask & ~rd.clear;
                end else if (rd.free[i]) begin
                    live[i]  <= 1'b0;
                    masks[i] <= '0;
                end else begin
                    masks[i] <= masks[i] & ~rd.clear;
                end
            end
        end
    end

    // Snapshot payload
    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_CKPT; i++) begin
            if (wr.write[i]) begin
                entries[i] <= wr.entry;
            end
        end
    end

    assign wr.live = live;

    assign rd.live    = live;
    assign rd.masks   = masks;
    assign rd.entries = entries;

endmodule

//--- hw/branch_resolver.sv
`timescale 1ns/10ps

module branch_resolver #(
    parameter int NUM_CKPT = bs_config_pkg::DEFAULT_NUM_CKPT
) (
    input  logic                                 resolve_valid,
    input  logic [NUM_CKPT-1:0]                  resolve_tag,
    input  logic                                 resolve_taken,
    input  logic [bs_config_pkg::XLEN-1:0]       resolve_target,
    input  logic [bs_config_pkg::XLEN-1:0]       resolve_npc,
    ckpt_read_if.resolver                        rd,
    output bs_types_pkg::resolve_e               outcome,
    output logic                                 correct_predict,
    output logic                                 mispredict,
    output logic [NUM_CKPT-1:0]                  resolved_branch,
    output logic [bs_config_pkg::XLEN-1:0]       redirect_pc,
    output logic [bs_config_pkg::ROB_IDX_W-1:0]  rob_tail_recovery,
    output logic [bs_config_pkg::LSQ_IDX_W-1:0]  lq_tail_recovery,
    output logic [bs_config_pkg::LSQ_IDX_W-1:0]  sq_tail_recovery
);
    import bs_config_pkg::*;
    import bs_types_pkg::*;

    checkpoint_t         sel;
    logic                hit;
    logic [XLEN-1:0]     expected_npc;
    logic [NUM_CKPT-1:0] younger;

    // Tag must name exactly one live slot
    always_comb begin
        sel = '0;
        hit = 1'b0;
        for (int i = 0; i < NUM_CKPT; i++) begin
            if (resolve_tag == (NUM_CKPT'(1) << i) && rd.live[i]) begin
                sel = rd.entries[i];
                hit = 1'b1;
            end
        end
    end

    assign expected_npc = resolve_taken ? resolve_target : sel.pc + XLEN'(4);

    always_comb begin
        if (!(resolve_valid && hit)) begin
            outcome = RES_NONE;
        end else if (expected_npc == resolve_npc) begin
            outcome = RES_CORRECT;
        end else begin
            outcome = RES_MISPREDICT;
        end
    end

    assign correct_predict = (outcome == RES_CORRECT);
    assign mispredict      = (outcome == RES_MISPREDICT);
    assign resolved_branch = (outcome != RES_NONE) ? resolve_tag : '0;

    // Branch itself and everything dispatched after it
    always_comb begin
        for (int i = 0; i < NUM_CKPT; i++) begin
            younger[i] = rd.live[i] && |(rd.masks[i] & resolve_tag);
        end
    end

    assign rd.free  = mispredict ? younger : (correct_predict ? resolve_tag : '0);
    assign rd.clear = correct_predict ? resolve_tag : '0;

    assign redirect_pc       = mispredict ? expected_npc : '0;
    assign rob_tail_recovery = mispredict ? sel.rob_tail : '0;
    assign lq_tail_recovery  = mispredict ? sel.lq_tail : '0;
    assign sq_tail_recovery  = mispredict ? sel.sq_tail : '0;

endmodule

//--- hw/branch_stack.sv
`timescale 1ns/10ps

module branch_stack #(
    parameter int NUM_CKPT = bs_config_pkg::DEFAULT_NUM_CKPT
) (
    input  logic                                 clock,
    input  logic                                 reset,

    // Dispatch of a conditional branch
    input  logic                                 dispatch_valid,
    input  logic [bs_config_pkg::XLEN-1:0]       dispatch_pc,
    input  logic [bs_config_pkg::ROB_IDX_W-1:0]  dispatch_rob_tail,
    input  logic [bs_config_pkg::LSQ_IDX_W-1:0]  dispatch_lq_tail,
    input  logic [bs_config_pkg::LSQ_IDX_W-1:0]  dispatch_sq_tail,
    output logic [NUM_CKPT-1:0]                  dispatch_tag,
    output logic                                 stack_full,

    // Outcome from execute
    input  logic                                 resolve_valid,
    input  logic [NUM_CKPT-1:0]                  resolve_tag,
    input  logic                                 resolve_taken,
    input  logic [bs_config_pkg::XLEN-1:0]       resolve_target,
    input  logic [bs_config_pkg::XLEN-1:0]       resolve_npc,

    // Recovery
    output logic                                 correct_predict,
    output logic                                 mispredict,
    output logic [NUM_CKPT-1:0]                  resolved_branch,
    output logic [bs_config_pkg::XLEN-1:0]       redirect_pc,
    output logic [bs_config_pkg::ROB_IDX_W-1:0]  rob_tail_recovery,
    output logic [bs_config_pkg::LSQ_IDX_W-1:0]  lq_tail_recovery,
    output logic [bs_config_pkg::LSQ_IDX_W-1:0]  sq_tail_recovery
);
    import bs_types_pkg::*;

    resolve_e outcome;

    ckpt_write_if #(.NUM_CKPT(NUM_CKPT)) wr_if ();
    ckpt_read_if #(.NUM_CKPT(NUM_CKPT)) rd_if ();

    checkpoint_alloc #(.NUM_CKPT(NUM_CKPT)) i_alloc (
        .dispatch_valid    (dispatch_valid),
        .dispatch_pc       (dispatch_pc),
        .dispatch_rob_tail (dispatch_rob_tail),
        .dispatch_lq_tail  (dispatch_lq_tail),
        .dispatch_sq_tail  (dispatch_sq_tail),
        .outcome           (outcome),
        .wr                (wr_if.alloc),
        .dispatch_tag      (dispatch_tag),
        .stack_full        (stack_full)
    );

    checkpoint_file #(.NUM_CKPT(NUM_CKPT)) i_file (
        .clock (clock),
        .reset (reset),
        .wr    (wr_if.file),
        .rd    (rd_if.file)
    );

    branch_resolver #(.NUM_CKPT(NUM_CKPT)) i_resolver (
        .resolve_valid     (resolve_valid),
        .resolve_tag       (resolve_tag),
        .resolve_taken     (resolve_taken),
        .resolve_target    (resolve_target),
        .resolve_npc       (resolve_npc),
        .rd                (rd_if.resolver),
        .outcome           (outcome),
        .correct_predict   (correct_predict),
        .mispredict        (mispredict),
        .resolved_branch   (resolved_branch),
        .redirect_pc       (redirect_pc),
        .rob_tail_recovery (rob_tail_recovery),
        .lq_tail_recovery  (lq_tail_recovery),
        .sq_tail_recovery  (sq_tail_recovery)
    );

endmodule

//--- tests/branch_stack_chk.sv
`timescale 1ns/10ps

module branch_stack_chk #(
    parameter int NUM_CKPT = bs_config_pkg::DEFAULT_NUM_CKPT
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                correct_predict,
    input  logic                                mispredict,
    input  logic [NUM_CKPT-1:0]                 dispatch_tag,
    input  logic [bs_config_pkg::XLEN-1:0]      redirect_pc,
    input  logic [bs_config_pkg::ROB_IDX_W-1:0] rob_tail_recovery,
    input  logic [bs_config_pkg::LSQ_IDX_W-1:0] lq_tail_recovery,
    input  logic [bs_config_pkg::LSQ_IDX_W-1:0] sq_tail_recovery
);
    int fail_count = 0;

    one_outcome: assert property (@(posedge clock) disable iff (reset)
        !(correct_predict && mispredict))
        else begin
            $error("correct_predict and mispredict are high together");
            fail_count++;
        end

    tag_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot(dispatch_tag))
        else begin
            $error("dispatch_tag is not one-hot");
            fail_count++;
        end

    // Recovery bus idles at zero
    quiet_recovery: assert property (@(posedge clock) disable iff (reset)
        !mispredict |-> (redirect_pc == '0 && rob_tail_recovery == '0
                         && lq_tail_recovery == '0 && sq_tail_recovery == '0))
        else begin
            $error("recovery outputs are nonzero without a mispredict");
            fail_count++;
        end

endmodule

//--- tests/bs_scoreboard.sv
`timescale 1ns/10ps

module bs_scoreboard #(
    parameter int NUM_CKPT = bs_config_pkg::DEFAULT_NUM_CKPT
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                test_done,
    input  int                                  test_id,
    input  logic                                dispatch_valid,
    input  logic                                resolve_valid,
    input  logic                                resolve_taken,
    input  logic                                stack_full,
    input  logic                                correct_predict,
    input  logic                                mispredict,
    input  logic [NUM_CKPT-1:0]                 dispatch_tag,
    input  logic [NUM_CKPT-1:0]                 resolve_tag,
    input  logic [NUM_CKPT-1:0]                 resolved_branch,
    input  logic [bs_config_pkg::XLEN-1:0]      dispatch_pc,
    input  logic [bs_config_pkg::XLEN-1:0]      resolve_target,
    input  logic [bs_config_pkg::XLEN-1:0]      resolve_npc,
    input  logic [bs_config_pkg::XLEN-1:0]      redirect_pc,
    input  logic [bs_config_pkg::ROB_IDX_W-1:0] dispatch_rob_tail,
    input  logic [bs_config_pkg::ROB_IDX_W-1:0] rob_tail_recovery,
    input  logic [bs_config_pkg::LSQ_IDX_W-1:0] dispatch_lq_tail,
    input  logic [bs_config_pkg::LSQ_IDX_W-1:0] dispatch_sq_tail,
    input  logic [bs_config_pkg::LSQ_IDX_W-1:0] lq_tail_recovery,
    input  logic [bs_config_pkg::LSQ_IDX_W-1:0] sq_tail_recovery,
    output int                                  errors,
    output int                                  checks
);
    import bs_config_pkg::*;

    logic [NUM_CKPT-1:0]  model_live;
    logic [NUM_CKPT-1:0]  model_mask [NUM_CKPT];
    logic [XLEN-1:0]      model_pc [NUM_CKPT];
    logic [ROB_IDX_W-1:0] model_rob [NUM_CKPT];
    logic [LSQ_IDX_W-1:0] model_lq [NUM_CKPT];
    logic [LSQ_IDX_W-1:0] model_sq [NUM_CKPT];
    int                   test_errors;
    int                   test_checks;

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // Compare and step the model on the falling edge
    always @(negedge clock) begin
        logic                full;
        logic                hit;
        logic                good;
        logic                bad;
        int                  slot;
        int                  idx;
        logic [XLEN-1:0]     npc;
        logic [NUM_CKPT-1:0] next_live;
        if (reset) begin
            model_live = '0;
            errors = 0;
            checks = 0;
            test_errors = 0;
            test_checks = 0;
        end else begin
            full = &model_live;
            // Lowest free slot, slot 0 when full
            slot = 0;
            for (int i = NUM_CKPT - 1; i >= 0; i--) begin
                if (!model_live[i]) begin
                    slot = i;
                end
            end
            idx = 0;
            for (int i = 0; i < NUM_CKPT; i++) begin
                if (resolve_tag[i]) begin
                    idx = i;
                end
            end
            hit  = resolve_valid && $onehot(resolve_tag) && model_live[idx];
            npc  = resolve_taken ? resolve_target : model_pc[idx] + XLEN'(4);
            good = hit && (npc == resolve_npc);
            bad  = hit && !good;

            compare("dispatch_tag", 32'(dispatch_tag), 32'(1) << slot);
            compare("stack_full", 32'(stack_full), 32'(full));
            compare("correct_predict", 32'(correct_predict), 32'(good));
            compare("mispredict", 32'(mispredict), 32'(bad));
            compare("resolved_branch", 32'(resolved_branch), hit ? 32'(resolve_tag) : 32'd0);
            compare("redirect_pc", 32'(redirect_pc), bad ? 32'(npc) : 32'd0);
            compare("rob_tail_recovery", 32'(rob_tail_recovery), bad ? 32'(model_rob[idx]) : 0);
            compare("lq_tail_recovery", 32'(lq_tail_recovery), bad ? 32'(model_lq[idx]) : 0);
            compare("sq_tail_recovery", 32'(sq_tail_recovery), bad ? 32'(model_sq[idx]) : 0);
            checks++;
            test_checks++;

            next_live = model_live;
            if (good) begin
                next_live[idx] = 1'b0;
                for (int i = 0; i < NUM_CKPT; i++) begin
                    model_mask[i][idx] = 1'b0;
                end
            end
            // Flush the branch and everything younger
            if (bad) begin
                for (int i = 0; i < NUM_CKPT; i++) begin
                    if (model_live[i] && model_mask[i][idx]) begin
                        next_live[i] = 1'b0;
                    end
                end
            end
            if (dispatch_valid && !full && !bad) begin
                next_live[slot]  = 1'b1;
                model_mask[slot] = model_live | (NUM_CKPT'(1) << slot);
                if (good) begin
                    model_mask[slot][idx] = 1'b0;
                end
                model_pc[slot]  = dispatch_pc;
                model_rob[slot] = dispatch_rob_tail;
                model_lq[slot]  = dispatch_lq_tail;
                model_sq[slot]  = dispatch_sq_tail;
            end
            model_live = next_live;

            if (test_done) begin
                $display("Test %0d finished: %0d cycles checked, %0d mismatches",
                         test_id, test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

//--- tests/tb_branch_stack.sv
`timescale 1ns/10ps

module tb_branch_stack;
    import bs_config_pkg::*;

    localparam int NUM_CKPT       = DEFAULT_NUM_CKPT;
    localparam int NUM_TESTS      = 5;
    localparam int TEST_CYCLES    = 200;
    localparam int TIMEOUT_CYCLES = 2 * NUM_TESTS * TEST_CYCLES;

    logic                 clock;
    logic                 reset;
    logic                 dispatch_valid;
    logic [XLEN-1:0]      dispatch_pc;
    logic [ROB_IDX_W-1:0] dispatch_rob_tail;
    logic [LSQ_IDX_W-1:0] dispatch_lq_tail;
    logic [LSQ_IDX_W-1:0] dispatch_sq_tail;
    logic [NUM_CKPT-1:0]  dispatch_tag;
    logic                 stack_full;
    logic                 resolve_valid;
    logic [NUM_CKPT-1:0]  resolve_tag;
    logic                 resolve_taken;
    logic [XLEN-1:0]      resolve_target;
    logic [XLEN-1:0]      resolve_npc;
    logic                 correct_predict;
    logic                 mispredict;
    logic [NUM_CKPT-1:0]  resolved_branch;
    logic [XLEN-1:0]      redirect_pc;
    logic [ROB_IDX_W-1:0] rob_tail_recovery;
    logic [LSQ_IDX_W-1:0] lq_tail_recovery;
    logic [LSQ_IDX_W-1:0] sq_tail_recovery;
    logic                 test_done;
    int                   test_id;
    int                   errors;
    int                   checks;
    int                   cycle_count = 0;

    branch_stack #(.NUM_CKPT(NUM_CKPT)) i_branch_stack (.*);

    bs_scoreboard #(.NUM_CKPT(NUM_CKPT)) i_sb (.*);

    bind branch_stack branch_stack_chk #(.NUM_CKPT(NUM_CKPT)) i_chk (
        .clock             (clock),
        .reset             (reset),
        .correct_predict   (correct_predict),
        .mispredict        (mispredict),
        .dispatch_tag      (dispatch_tag),
        .redirect_pc       (redirect_pc),
        .rob_tail_recovery (rob_tail_recovery),
        .lq_tail_recovery  (lq_tail_recovery),
        .sq_tail_recovery  (sq_tail_recovery)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // One cycle of random traffic, resolving only slots the model holds live
    task automatic drive_cycle(input int disp_pct, input int res_pct, input int mis_pct);
        logic [NUM_CKPT-1:0] live;
        int                  picks [$];
        int                  idx;
        logic [XLEN-1:0]     good_npc;
        @(posedge clock);
        #1;
        live = i_sb.model_live;
        dispatch_valid    = ($urandom % 100) < disp_pct;
        dispatch_pc       = XLEN'($urandom);
        dispatch_rob_tail = ROB_IDX_W'($urandom);
        dispatch_lq_tail  = LSQ_IDX_W'($urandom);
        dispatch_sq_tail  = LSQ_IDX_W'($urandom);
        for (int i = 0; i < NUM_CKPT; i++) begin
            if (live[i]) begin
                picks.push_back(i);
            end
        end
        idx = 0;
        resolve_valid = 1'b0;
        if (picks.size() > 0) begin
            idx = picks[$urandom % picks.size()];
            resolve_valid = ($urandom % 100) < res_pct;
        end
        resolve_tag    = NUM_CKPT'(1) << idx;
        resolve_taken  = 1'($urandom);
        resolve_target = XLEN'($urandom);
        good_npc = resolve_taken ? resolve_target : i_sb.model_pc[idx] + XLEN'(4);
        resolve_npc = good_npc;
        if (($urandom % 100) < mis_pct) begin
            resolve_npc = good_npc ^ XLEN'($urandom | 1);
        end
    endtask

    task automatic run_test(input int id, input int disp_pct, input int res_pct,
                            input int mis_pct);
        test_id = id;
        repeat (TEST_CYCLES) drive_cycle(disp_pct, res_pct, mis_pct);
        @(posedge clock);
        #1;
        dispatch_valid = 1'b0;
        resolve_valid  = 1'b0;
        test_done      = 1'b1;
        @(posedge clock);
        #1;
        test_done = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hb6e0f53e));
        clock             = 1'b0;
        reset             = 1'b1;
        test_done         = 1'b0;
        test_id           = 0;
        dispatch_valid    = 1'b0;
        dispatch_pc       = '0;
        dispatch_rob_tail = '0;
        dispatch_lq_tail  = '0;
        dispatch_sq_tail  = '0;
        resolve_valid     = 1'b0;
        resolve_tag       = '0;
        resolve_taken     = 1'b0;
        resolve_target    = '0;
        resolve_npc       = '0;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        // Fill the stack with few resolves
        run_test(1, 70, 20, 0);
        run_test(2, 40, 50, 0);
        run_test(3, 50, 40, 70);
        // Deep stack with mixed outcomes
        run_test(4, 60, 30, 30);
        // Dispatch and resolve nearly every cycle
        run_test(5, 90, 80, 30);

        $display("Checked %0d cycles: %0d mismatches, %0d assertion failures",
                 checks, errors, i_branch_stack.i_chk.fail_count);
        if (errors == 0 && i_branch_stack.i_chk.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- compile.f
hw/bs_config_pkg.sv
hw/bs_types_pkg.sv
hw/ckpt_write_if.sv
hw/ckpt_read_if.sv
hw/checkpoint_alloc.sv
hw/checkpoint_file.sv
hw/branch_resolver.sv
hw/branch_stack.sv
tests/branch_stack_chk.sv
tests/bs_scoreboard.sv
tests/tb_branch_stack.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_branch_stack -f compile.f -o tb_sim \
    > sim.log 2>&1 &&
    ./obj_dir/tb_sim +verilator+error+limit+1000 >> sim.log 2>&1
cat sim.log
grep -qx "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
